//--- design/tx_dp_consts.svh
// Bit positions assume two 40-bit lanes in one 80-bit word and must move with TX_LANE_W
`ifndef TX_DP_CONSTS_SVH
`define TX_DP_CONSTS_SVH

//*********************************************************************
// Widths
//*********************************************************************
`define TX_LANE_W     40   // One transmit word
`define TX_FIFO_AW    4    // 16 entries, 3 and 5 also work
`define TX_WA_CNT_W   4    // Error count stops at all ones

//*********************************************************************
// Bit positions in the 80-bit output word
//*********************************************************************
// Upper lane is lane 1, lower lane is lane 0
`define TX_BIT_HDR_HI 79   // Upper header expected high
`define TX_BIT_START  77   // Start of sequence marker
`define TX_BIT_HDR_LO 39   // Lower header expected low
`define TX_BIT_DV     36   // Data valid bit

`endif

//--- design/tx_dp_pkg.sv
// Both union views are exactly two lanes wide and the field layout follows the bit macros
`include "tx_dp_consts.svh"

package tx_dp_pkg;

   //*********************************************************************
   // Lane and pair types
   //*********************************************************************
   typedef logic [`TX_LANE_W-1:0] tx_lane_t;   // One transmit word

   // Field view of the pair, MSB first
   typedef struct packed {
      logic                                    hdr_hi;       // Upper sync header
      logic [`TX_BIT_HDR_HI-`TX_BIT_START-2:0] upr_rest;     // Bit 78
      logic                                    start;        // Start of sequence
      logic [`TX_BIT_START-`TX_LANE_W-1:0]     upr_payload;  // Bits 76 down to 40
      logic                                    hdr_lo;       // Lower sync header
      logic [`TX_BIT_HDR_LO-`TX_BIT_DV-2:0]    lwr_pay_hi;   // Bits 38 and 37
      logic                                    dv;           // Data valid
      logic [`TX_BIT_DV-1:0]                   lwr_pay_lo;   // Bits 35 down to 0
   } tx_pair_fields_t;

   // Same 80 bits seen by lane or by field
   typedef union packed {
      tx_lane_t [1:0]  lane;   // Lane 1 on top
      tx_pair_fields_t f;      // Header, start and DV decode
   } tx_pair_u;

   //*********************************************************************
   // Constants
   //*********************************************************************
   // Idle word with only the upper header set
   localparam tx_pair_u tx_pair_default = {1'b1, {(2*`TX_LANE_W-1){1'b0}}};

endpackage

//--- design/tx_dp_fifo.sv
// Single clock only; pop must be raised only while pair_avail is high and it always takes two words
`timescale 1ns/1ps
`include "tx_dp_consts.svh"

module tx_dp_fifo
   import tx_dp_pkg::*;
(
   input  logic     rd_clk,       // Datapath clock
   input  logic     rd_rst_n,     // Async reset, active low
   input  logic     srst,         // Sync clear, active high
   input  logic     in_valid,     // Source offers a word
   input  tx_lane_t in_data,      // Word from source
   input  logic     pop,          // Remove the two oldest words
   output logic     in_ready,     // Room for one more word
   output logic     pair_avail,   // Two or more words stored
   output tx_lane_t head_word,    // Oldest word
   output tx_lane_t next_word,    // Second oldest word
   output logic     fifo_empty,   // Nothing stored
   output logic     fifo_full     // All entries used
);

   //*********************************************************************
   // Sizes and local types
   //*********************************************************************
   localparam int DEPTH = 1 << `TX_FIFO_AW;   // 16 entries at the default width

   typedef logic [`TX_FIFO_AW-1:0] ptr_t;     // Wraps on its own
   typedef logic [`TX_FIFO_AW:0]   cnt_t;     // Extra bit to reach DEPTH

   localparam cnt_t FULL_CNT = cnt_t'(DEPTH);

   tx_lane_t mem [DEPTH];   // Register array
   ptr_t     wr_ptr;        // Next slot to write
   ptr_t     rd_ptr;        // Oldest word
   ptr_t     rd_ptr_nxt;    // Slot after the oldest
   cnt_t     count;         // Words stored
   logic     push;          // Accepted input word

   //*********************************************************************
   // Handshake and status
   //*********************************************************************
   assign push       = in_valid & in_ready;      // Input transfer
   assign in_ready   = ~fifo_full;               // Free while not full
   assign fifo_full  = (count == FULL_CNT);
   assign fifo_empty = (count == cnt_t'(0));
   assign pair_avail = (count >= cnt_t'(2));     // Double read needs two words

   assign rd_ptr_nxt = rd_ptr + ptr_t'(1);       // Wrap at the top entry
   assign head_word  = mem[rd_ptr];
   assign next_word  = mem[rd_ptr_nxt];

   // Storage write, payload only
   always_ff @(posedge rd_clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   //*********************************************************************
   // Pointers and count
   //*********************************************************************
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (srst) begin
         wr_ptr <= '0;                           // Drop everything queued
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (push) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + ptr_t'(2);         // Pair leaves at once
         end
         // Push adds one and pop removes two in the same edge
         count <= count + cnt_t'(push) - cnt_t'({pop, 1'b0});
      end
   end

endmodule

//--- design/tx_dp_pair_out.sv
// srst takes priority over hold; bit 36 is combinational from the start latch when gating is on
`timescale 1ns/1ps

module tx_dp_pair_out
   import tx_dp_pkg::*;
(
   input  logic     rd_clk,       // Datapath clock
   input  logic     rd_rst_n,     // Async reset, active low
   input  logic     srst,         // Sync clear, active high
   input  logic     hold,         // Freeze the output word
   input  logic     dv_gate_en,   // Gate bit 36 until start seen
   input  logic     pair_avail,   // FIFO holds a pair
   input  tx_lane_t head_word,    // Goes to lane 0
   input  tx_lane_t next_word,    // Goes to lane 1
   input  logic     out_ready,    // Sink takes the word
   output logic     pop,          // Take the pair from FIFO
   output logic     out_valid,    // Output word pending
   output tx_pair_u out_data      // Output word, bit 36 gated
);

   //*********************************************************************
   // Local state
   //*********************************************************************
   tx_pair_u data_q;     // Output register, ungated
   logic     start_lt;   // Start of sequence seen
   logic     xfer;       // Output transfer this cycle
   logic     dv_open;    // DV may pass

   assign xfer = out_valid & out_ready;

   // Load when the slot is empty or drains at this edge
   assign pop = pair_avail & ~hold & ~srst & (~out_valid | out_ready);

   //*********************************************************************
   // Output register
   //*********************************************************************
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         data_q    <= tx_pair_default;
         out_valid <= 1'b0;
      end
      else if (srst) begin
         data_q    <= tx_pair_default;           // Back to idle word
         out_valid <= 1'b0;
      end
      else if (hold) begin
         data_q    <= data_q;                    // Frozen regardless of sink
         out_valid <= out_valid;
      end
      else if (pop) begin
         data_q.lane[0] <= head_word;            // Older word low
         data_q.lane[1] <= next_word;            // Newer word high
         out_valid      <= 1'b1;
      end
      else if (xfer) begin
         data_q    <= tx_pair_default;           // Drained with nothing behind
         out_valid <= 1'b0;
      end
   end

   //*********************************************************************
   // Start of sequence latch
   //*********************************************************************
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         start_lt <= 1'b0;
      end
      else if (srst) begin
         start_lt <= 1'b0;
      end
      else if (out_valid && data_q.f.start) begin
         start_lt <= 1'b1;                       // Stays set until clear
      end
   end

   //*********************************************************************
   // Data valid gate
   //*********************************************************************
   // The word carrying bit 77 already passes its own DV
   assign dv_open = start_lt | data_q.f.start;

   always_comb begin
      out_data      = data_q;
      out_data.f.dv = dv_gate_en ? (data_q.f.dv & dv_open) : data_q.f.dv;
   end

endmodule

//--- design/tx_dp_align_mon.sv
// Checks only words that transfer with wa_en high; the count saturates and only srst clears it
`timescale 1ns/1ps
`include "tx_dp_consts.svh"

module tx_dp_align_mon
   import tx_dp_pkg::*;
(
   input  logic                    rd_clk,         // Datapath clock
   input  logic                    rd_rst_n,       // Async reset, active low
   input  logic                    srst,           // Sync clear, active high
   input  logic                    wa_en,          // Word align check on
   input  logic                    out_valid,      // Output handshake
   input  logic                    out_ready,
   input  tx_pair_u                out_data,       // Word on the output
   output logic                    wa_error,       // Sticky error flag
   output logic [`TX_WA_CNT_W-1:0] wa_error_cnt    // Errors seen, saturating
);

   localparam logic [`TX_WA_CNT_W-1:0] CNT_MAX = '1;
   localparam logic [`TX_WA_CNT_W-1:0] CNT_ONE = {{(`TX_WA_CNT_W-1){1'b0}}, 1'b1};

   logic hdr_bad;   // Header wrong on a transfer

   // Lower header must be low and upper header must be high
   assign hdr_bad = wa_en & out_valid & out_ready &
                    (out_data.f.hdr_lo | ~out_data.f.hdr_hi);

   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         wa_error     <= 1'b0;
         wa_error_cnt <= '0;
      end
      else if (srst) begin
         wa_error     <= 1'b0;
         wa_error_cnt <= '0;
      end
      else if (hdr_bad) begin
         wa_error <= 1'b1;                          // Held until srst
         if (wa_error_cnt != CNT_MAX) begin
            wa_error_cnt <= wa_error_cnt + CNT_ONE;   // Stops at all ones
         end
      end
   end

endmodule

//--- design/tx_dp_top.sv
// Single rd_clk domain; srst clears the FIFO, output word and align status in one cycle
`timescale 1ns/1ps
`include "tx_dp_consts.svh"

module tx_dp_top
   import tx_dp_pkg::*;
(
   input  logic                    rd_clk,         // Datapath clock
   input  logic                    rd_rst_n,       // Async reset, active low
   input  logic                    srst,           // Sync clear, active high
   input  logic                    hold,           // Freeze output word
   input  logic                    wa_en,          // Word align check on
   input  logic                    dv_gate_en,     // Gate DV until start
   input  logic                    in_valid,       // Input handshake
   input  tx_lane_t                in_data,
   input  logic                    out_ready,      // Sink ready
   output logic                    in_ready,
   output logic                    out_valid,      // Output handshake
   output tx_pair_u                out_data,
   output logic                    fifo_empty,     // FIFO status
   output logic                    fifo_full,
   output logic                    wa_error,       // Align status
   output logic [`TX_WA_CNT_W-1:0] wa_error_cnt
);

   //*********************************************************************
   // FIFO to output register
   //*********************************************************************
   logic     pair_avail;   // Two words ready
   logic     pop;          // Pair taken
   tx_lane_t head_word;    // Oldest
   tx_lane_t next_word;    // Second oldest

   tx_dp_fifo u_fifo (
      .rd_clk     (rd_clk),
      .rd_rst_n   (rd_rst_n),
      .srst       (srst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .pop        (pop),
      .in_ready   (in_ready),
      .pair_avail (pair_avail),
      .head_word  (head_word),
      .next_word  (next_word),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full)
   );

   tx_dp_pair_out u_pair_out (
      .rd_clk     (rd_clk),
      .rd_rst_n   (rd_rst_n),
      .srst       (srst),
      .hold       (hold),
      .dv_gate_en (dv_gate_en),
      .pair_avail (pair_avail),
      .head_word  (head_word),
      .next_word  (next_word),
      .out_ready  (out_ready),
      .pop        (pop),
      .out_valid  (out_valid),
      .out_data   (out_data)
   );

   // Monitor sees the word as the sink does
   tx_dp_align_mon u_align_mon (
      .rd_clk       (rd_clk),
      .rd_rst_n     (rd_rst_n),
      .srst         (srst),
      .wa_en        (wa_en),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_data     (out_data),
      .wa_error     (wa_error),
      .wa_error_cnt (wa_error_cnt)
   );

endmodule

//--- verif/tx_dp_chk.sv
// Bound into tx_dp_top; all checks are off while rd_rst_n is low and dv_gate_en must not move under hold
`timescale 1ns/1ps
`include "tx_dp_consts.svh"

module tx_dp_chk
   import tx_dp_pkg::*;
(
   input logic                    rd_clk,         // Datapath clock
   input logic                    rd_rst_n,       // Async reset, active low
   input logic                    srst,           // Sync clear
   input logic                    hold,           // Output freeze
   input logic                    in_valid,       // Input side
   input logic                    in_ready,
   input logic                    fifo_full,
   input logic                    out_valid,      // Output side
   input logic                    out_ready,
   input tx_pair_u                out_data,
   input logic [`TX_WA_CNT_W-1:0] wa_error_cnt    // Align error count
);

   int fail_cnt;   // Assertions that fired

   // Full is only reached through an accepted word
   a_full_by_push: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      (in_ready && !in_valid) |=> !fifo_full)
   else begin
      fail_cnt++;
      $error("fifo_full rose without an accepted word");
   end

   // Stalled or held word must not move
   a_out_stable: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      (((out_valid && !out_ready) || hold) && !srst) |=>
         ($stable(out_valid) && $stable(out_data)))
   else begin
      fail_cnt++;
      $error("output word changed while stalled or held");
   end

   // Count only climbs until a clear
   a_cnt_mono: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      !srst |=> (wa_error_cnt >= $past(wa_error_cnt)))
   else begin
      fail_cnt++;
      $error("wa_error_cnt fell without srst");
   end

endmodule

bind tx_dp_top tx_dp_chk u_chk (
   .rd_clk       (rd_clk),
   .rd_rst_n     (rd_rst_n),
   .srst         (srst),
   .hold         (hold),
   .in_valid     (in_valid),
   .in_ready     (in_ready),
   .fifo_full    (fifo_full),
   .out_valid    (out_valid),
   .out_ready    (out_ready),
   .out_data     (out_data),
   .wa_error_cnt (wa_error_cnt)
);

//--- verif/tx_dp_tb.sv
// Needs --timing; the cycle model assumes the FIFO depth from TX_FIFO_AW and even word counts
`timescale 1ns/1ps
`include "tx_dp_consts.svh"

module tx_dp_tb
   import tx_dp_pkg::*;
();

   localparam int DEPTH = 1 << `TX_FIFO_AW;   // FIFO entries

   logic                    rd_clk, rd_rst_n, srst, hold;              // Clock and control
   logic                    wa_en, dv_gate_en, in_valid, out_ready;
   tx_lane_t                in_data;                                   // Source word
   logic                    in_ready, out_valid, fifo_empty, fifo_full, wa_error;
   tx_pair_u                out_data;                                  // Sink word
   logic [`TX_WA_CNT_W-1:0] wa_error_cnt;

   //*********************************************************************
   // Reference model and stimulus state
   //*********************************************************************
   tx_lane_t                fq[$];                  // Words inside the FIFO
   tx_pair_u                m_reg;                  // Output register
   logic                    m_valid, m_start, m_err;
   logic [`TX_WA_CNT_W-1:0] m_cnt;                  // Saturating error count
   logic [31:0]             rng = 32'd74028;        // Xorshift state
   logic                    cfg_wa, cfg_dv, pushed, lane_sel, hung;
   int                      word_mode, words_sent, errors, checks, tests, test_errs;
   string                   test_name;

   tx_dp_top u_tx_dp_top (.*);

   initial rd_clk = 1'b0;
   always #50 rd_clk = ~rd_clk;                     // 100 ns period

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Mode 1 biases headers toward legal, mode 2 makes start bits rare
   function automatic tx_lane_t make_word();
      logic [31:0] lo;
      logic [31:0] hi;
      tx_lane_t    w;
      lo = next_rand();
      hi = next_rand();
      w  = {hi[7:0], lo};
      if (word_mode == 1) w[39] = (hi[10:8] == 3'd0) ? ~lane_sel : lane_sel;
      if (word_mode == 2) w[37] = (hi[12:9] == 4'd0);
      lane_sel = ~lane_sel;                         // Next word lands in the other lane
      return w;
   endfunction

   function automatic tx_pair_u expected_out();
      tx_pair_u e;
      e = m_reg;
      if (dv_gate_en) e.f.dv = m_reg.f.dv & (m_start | m_reg.f.start);   // Wait for start
      return e;
   endfunction

   //*********************************************************************
   // Compare tasks
   //*********************************************************************
   task automatic check_pair(input string what, input tx_pair_u exp, input tx_pair_u act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_cnt(input string what, input logic [`TX_WA_CNT_W-1:0] exp,
                            input logic [`TX_WA_CNT_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   //*********************************************************************
   // One cycle: drive on the falling edge, check, then advance the model
   //*********************************************************************
   task automatic model_edge();
      logic xfer;
      xfer   = m_valid & out_ready;
      pushed = in_valid & (fq.size() < DEPTH);
      if (pushed) words_sent++;
      if (srst) begin
         fq.delete();                               // Everything queued is dropped
         m_reg   = tx_pair_default;
         m_valid = 1'b0;
         m_start = 1'b0;
         m_err   = 1'b0;
         m_cnt   = '0;
      end
      else begin
         if (wa_en && xfer && (m_reg.f.hdr_lo || !m_reg.f.hdr_hi)) begin
            m_err = 1'b1;
            if (m_cnt != '1) m_cnt++;               // Saturates at all ones
         end
         if (m_valid && m_reg.f.start) m_start = 1'b1;
         if ((fq.size() >= 2) && !hold && (!m_valid || out_ready)) begin
            m_reg.lane[0] = fq.pop_front();         // Older word low
            m_reg.lane[1] = fq.pop_front();
            m_valid       = 1'b1;
         end
         else if (xfer && !hold) begin
            m_reg   = tx_pair_default;
            m_valid = 1'b0;
         end
         if (pushed) fq.push_back(in_data);
      end
   endtask

   task automatic step(input logic want, input logic rdy, input logic hld, input logic clr);
      @(negedge rd_clk);
      if (pushed) in_valid = 1'b0;                  // Word went in at the last edge
      if (want && !in_valid) begin
         in_data  = make_word();
         in_valid = 1'b1;
      end
      out_ready  = rdy;
      hold       = hld;
      srst       = clr;
      wa_en      = cfg_wa;
      dv_gate_en = cfg_dv;
      #1;
      check_bit("in_ready", fq.size() < DEPTH, in_ready);
      check_bit("fifo_full", fq.size() == DEPTH, fifo_full);
      check_bit("fifo_empty", fq.size() == 0, fifo_empty);
      check_bit("out_valid", m_valid, out_valid);
      check_pair("out_data", expected_out(), out_data);
      check_bit("wa_error", m_err, wa_error);
      check_cnt("wa_error_cnt", m_cnt, wa_error_cnt);
      model_edge();
   endtask

   // rdy_mode 0 stalls the sink, 1 keeps it ready, 2 is random
   task automatic send_words(input int n, input int rdy_mode, input logic use_hold);
      int          target;
      int          guard;
      logic [31:0] r;
      target = words_sent + n;
      guard  = 0;
      while (words_sent < target && !hung) begin
         r = next_rand();
         step(1'b1, (rdy_mode == 2) ? r[0] : (rdy_mode == 1), use_hold & (r[3:1] < 3'd3),
              1'b0);
         guard++;
         if (guard > 40 * n) begin
            hung = 1'b1;
            $display("Timeout in %s: the FIFO stopped accepting words", test_name);
         end
      end
   endtask

   task automatic drain();
      int guard;
      guard = 0;
      while ((fq.size() > 1 || m_valid || in_valid) && !hung) begin
         step(1'b0, 1'b1, 1'b0, 1'b0);
         guard++;
         if (guard > 4 * DEPTH) begin
            hung = 1'b1;
            $display("Timeout in %s: the output never drained", test_name);
         end
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_errs = errors;
      tests++;
   endtask

   task automatic end_test();
      $display("%s done, %0d errors", test_name, errors - test_errs);
   endtask

   //*********************************************************************
   // Test sequence
   //*********************************************************************
   initial begin
      {srst, hold, wa_en, dv_gate_en, in_valid, out_ready} = '0;
      {cfg_wa, cfg_dv, pushed, lane_sel, m_valid, m_start, m_err, hung} = '0;
      in_data  = '0;
      m_reg    = tx_pair_default;
      m_cnt    = '0;
      rd_rst_n = 1'b0;
      repeat (8) @(posedge rd_clk);                 // Reset for 8 cycles
      @(negedge rd_clk);
      rd_rst_n = 1'b1;

      begin_test("default_clear");
      check_pair("reset out_data", tx_pair_default, out_data);
      check_bit("reset out_valid", 1'b0, out_valid);
      check_bit("reset in_ready", 1'b1, in_ready);
      check_bit("reset fifo_empty", 1'b1, fifo_empty);
      check_cnt("reset wa_error_cnt", '0, wa_error_cnt);
      send_words(10, 0, 1'b0);                      // Queue up behind a stalled sink
      step(1'b0, 1'b0, 1'b0, 1'b1);
      step(1'b0, 1'b1, 1'b0, 1'b0);
      check_pair("clear out_data", tx_pair_default, out_data);
      check_bit("clear out_valid", 1'b0, out_valid);
      send_words(4, 1, 1'b0);                       // Only these may come out
      drain();
      end_test();

      begin_test("pairing");
      send_words(64, 1, 1'b0);
      drain();
      end_test();

      begin_test("backpressure");
      send_words(DEPTH + 2, 0, 1'b0);               // FIFO plus output register
      repeat (4) step(1'b1, 1'b0, 1'b0, 1'b0);      // Full, next word waits
      send_words(64, 2, 1'b0);
      drain();
      end_test();

      begin_test("hold");
      send_words(48, 2, 1'b1);
      drain();
      end_test();

      begin_test("word_align");
      step(1'b0, 1'b1, 1'b0, 1'b1);
      cfg_wa    = 1'b1;
      word_mode = 1;
      lane_sel  = 1'b0;
      send_words(160, 2, 1'b0);
      drain();
      cfg_wa    = 1'b0;
      word_mode = 0;
      step(1'b0, 1'b1, 1'b0, 1'b1);                 // Sticky flag only clears here
      step(1'b0, 1'b1, 1'b0, 1'b0);
      check_bit("wa_error after srst", 1'b0, wa_error);
      end_test();

      begin_test("dv_gate");
      cfg_dv    = 1'b1;
      word_mode = 2;
      step(1'b0, 1'b1, 1'b0, 1'b1);                 // Start latch cleared
      send_words(64, 2, 1'b0);
      drain();
      cfg_dv    = 1'b0;
      word_mode = 0;
      step(1'b0, 1'b1, 1'b0, 1'b0);
      end_test();

      $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d", tests, checks,
               errors, u_tx_dp_top.u_chk.fail_cnt);
      if (errors == 0 && !hung && u_tx_dp_top.u_chk.fail_cnt == 0) begin
         $display("test passed");
      end
      else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+design
design/tx_dp_pkg.sv
design/tx_dp_fifo.sv
design/tx_dp_pair_out.sv
design/tx_dp_align_mon.sv
design/tx_dp_top.sv
verif/tx_dp_chk.sv
verif/tx_dp_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run once, and decide on the pass line in the output
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f list.f --top-module tx_dp_tb --Mdir obj_dir -o tx_dp_sim \
   && ./obj_dir/tx_dp_sim | tee /dev/stderr | grep -qx "test passed" \
   && echo "Simulation result: PASS" \
   || { echo "Simulation result: FAIL"; exit 1; }
